//--- include/idct_defs.svh
// Size, SRAM layout and fixed-point constants of the IDCT engine, included by RTL and testbench
`ifndef IDCT_DEFS_SVH
`define IDCT_DEFS_SVH

// Block geometry
`define IDCT_N                  8

// SRAM layout, word addresses
`define COEFF_BASE              76800
`define IMG_WIDTH               320      // Coefficient words per image row
`define ROW_WORDS               160      // Two pixels per word
`define COEFF_BLOCK_ROW_STRIDE  2560     // 8 rows of 320 words
`define PIX_BLOCK_ROW_STRIDE    1280     // 8 rows of 160 words

// Cycles from address to read data
`define SRAM_RD_LATENCY         2

// Fixed-point bit positions
`define PASS1_SHIFT             8        // T keeps bits 23..8
`define PIXEL_LSB               16       // Pixel is bits 23..16
`define CLIP_BIT                24       // Sums at or above 2^24 saturate

`endif

//--- src/idct_pkg.sv
// Vector types and state encodings shared by the IDCT engine modules
package idct_pkg;

	typedef logic signed [15:0] sample_t;   // Coefficient or T element
	typedef logic signed [15:0] coeff_t;    // Cosine matrix entry
	typedef logic signed [39:0] acc_t;
	typedef logic [7:0]         pixel_t;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;

	typedef logic [5:0] mat_idx_t;          // Row * 8 + column
	typedef logic [4:0] blk_row_t;
	typedef logic [5:0] blk_col_t;

	typedef enum logic [2:0] {
		CTRL_IDLE,
		CTRL_FETCH,
		CTRL_PASS1,
		CTRL_PASS2,
		CTRL_DRAIN,
		CTRL_DONE
	} ctrl_state_t;

	typedef enum logic [1:0] {
		IO_IDLE,
		IO_READ,
		IO_WRITE
	} io_state_t;

endpackage

//--- src/dp_ram.sv
// Dual-port synchronous RAM, port a reads and writes, port b reads, one-cycle read latency
`timescale 1ns/1ns

module dp_ram #(
	parameter int WIDTH      = 16,
	parameter int DEPTH_LOG2 = 6
) (
	input  logic                  CLOCK_50_I,
	input  logic [DEPTH_LOG2-1:0] addr_a,
	input  logic [DEPTH_LOG2-1:0] addr_b,
	input  logic [WIDTH-1:0]      data_a,
	input  logic                  wren_a,
	output logic [WIDTH-1:0]      q_a,
	output logic [WIDTH-1:0]      q_b
);

	logic [WIDTH-1:0] mem [2**DEPTH_LOG2];

	always_ff @(posedge CLOCK_50_I) begin
		if (wren_a) begin
			mem[addr_a] <= data_a;
		end
		q_a <= mem[addr_a];   // Old data on a write
		q_b <= mem[addr_b];
	end

endmodule

//--- src/dct_coeff_rom.sv
// Registered two-port ROM of the fixed-point 8x8 cosine matrix, addressed row * 8 + column
`timescale 1ns/1ns

module dct_coeff_rom (
	input  logic               CLOCK_50_I,
	input  idct_pkg::mat_idx_t addr_a,
	input  idct_pkg::mat_idx_t addr_b,
	output idct_pkg::coeff_t   coeff_a,
	output idct_pkg::coeff_t   coeff_b
);

	// C[n][k] from the phase (2n+1)k folded into the first quadrant
	function automatic idct_pkg::coeff_t cos_entry(input logic [2:0] n, input logic [2:0] k);
		logic [7:0] prod;
		logic [4:0] m;
		logic neg;
		idct_pkg::coeff_t mag;
		begin
			prod = {4'd0, n, 1'b1} * {5'd0, k};
			m = prod[4:0];            // Phase mod 32
			neg = 1'b0;
			if (m > 5'd16) begin
				m = 5'd0 - m;         // cos(2pi - x)
			end
			if (m > 5'd8) begin
				m = 5'd16 - m;        // cos(pi - x) flips sign
				neg = 1'b1;
			end
			case (m)
				5'd1:    mag = 16'sd2008;
				5'd2:    mag = 16'sd1892;
				5'd3:    mag = 16'sd1702;
				5'd5:    mag = 16'sd1137;
				5'd6:    mag = 16'sd783;
				5'd7:    mag = 16'sd399;
				default: mag = 16'sd1448;
			endcase
			if (k == 3'd0) begin
				return 16'sd1448;     // DC column
			end
			return neg ? -mag : mag;
		end
	endfunction

	always_ff @(posedge CLOCK_50_I) begin
		coeff_a <= cos_entry(addr_a[5:3], addr_a[2:0]);
		coeff_b <= cos_entry(addr_b[5:3], addr_b[2:0]);
	end

endmodule

//--- src/sram_block_io.sv
// SRAM side of the IDCT engine, fetches the coefficient block and writes packed pixels back
`timescale 1ns/1ns
`include "idct_defs.svh"

module sram_block_io (
	input  logic                 CLOCK_50_I,
	input  logic                 resetn,
	input  logic                 fetch_start,
	input  idct_pkg::blk_row_t   block_row,
	input  idct_pkg::blk_col_t   block_col,
	input  idct_pkg::sram_data_t sram_read_data,
	output idct_pkg::sram_addr_t sram_address,
	output idct_pkg::sram_data_t sram_write_data,
	output logic                 sram_we_n,
	output idct_pkg::mat_idx_t   sp_wr_addr,
	output idct_pkg::sample_t    sp_wr_data,
	output logic                 sp_wr_en,
	output logic                 fetch_done,
	input  idct_pkg::pixel_t     pixel,
	input  logic                 pixel_valid,
	output logic                 write_done
);

	localparam int LAT = `SRAM_RD_LATENCY;

	idct_pkg::io_state_t  state;
	idct_pkg::sram_addr_t coeff_base;
	idct_pkg::sram_addr_t pix_base;
	idct_pkg::mat_idx_t   rd_cnt;
	logic                 rd_active;
	logic [LAT:0]         ret_vld;          // Bit 0 lines up with sram_address
	idct_pkg::mat_idx_t   ret_idx [LAT+1];
	idct_pkg::pixel_t     pix_hi;
	logic                 pix_odd;
	logic [4:0]           word_cnt;

	assign sp_wr_en   = ret_vld[LAT];
	assign sp_wr_addr = ret_idx[LAT];
	assign sp_wr_data = idct_pkg::sample_t'(sram_read_data);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state      <= idct_pkg::IO_IDLE;
			rd_active  <= 1'b0;
			rd_cnt     <= '0;
			ret_vld    <= '0;
			sram_we_n  <= 1'b1;
			fetch_done <= 1'b0;
			write_done <= 1'b0;
			pix_odd    <= 1'b0;
			word_cnt   <= '0;
		end else begin
			fetch_done <= 1'b0;
			write_done <= 1'b0;
			sram_we_n  <= 1'b1;
			ret_vld    <= {ret_vld[LAT-1:0], 1'b0};
			case (state)
				idct_pkg::IO_IDLE: begin
					if (fetch_start) begin
						state     <= idct_pkg::IO_READ;
						rd_active <= 1'b1;
						rd_cnt    <= '0;
						pix_odd   <= 1'b0;
						word_cnt  <= '0;
					end
				end
				idct_pkg::IO_READ: begin
					if (rd_active) begin
						ret_vld[0] <= 1'b1;
						rd_cnt     <= rd_cnt + 6'd1;
						if (rd_cnt == 6'd63) begin
							rd_active <= 1'b0;
						end
					end
					if (sp_wr_en && sp_wr_addr == 6'd63) begin   // Last coefficient stored
						fetch_done <= 1'b1;
						state      <= idct_pkg::IO_WRITE;
					end
				end
				idct_pkg::IO_WRITE: begin
					if (pixel_valid) begin
						pix_odd <= ~pix_odd;
						if (pix_odd) begin
							sram_we_n <= 1'b0;
							word_cnt  <= word_cnt + 5'd1;
						end
					end
					if (!sram_we_n && word_cnt == 5'd0) begin    // Word 31 just went out
						write_done <= 1'b1;
						state      <= idct_pkg::IO_IDLE;
					end
				end
				default: state <= idct_pkg::IO_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (state == idct_pkg::IO_IDLE && fetch_start) begin
			coeff_base <= idct_pkg::sram_addr_t'(`COEFF_BASE)
				+ idct_pkg::sram_addr_t'(block_row) * idct_pkg::sram_addr_t'(`COEFF_BLOCK_ROW_STRIDE)
				+ idct_pkg::sram_addr_t'(block_col) * idct_pkg::sram_addr_t'(`IDCT_N);
			pix_base <= idct_pkg::sram_addr_t'(block_row) * idct_pkg::sram_addr_t'(`PIX_BLOCK_ROW_STRIDE)
				+ idct_pkg::sram_addr_t'(block_col) * idct_pkg::sram_addr_t'(`IDCT_N / 2);
		end
		if (state == idct_pkg::IO_READ && rd_active) begin
			sram_address <= coeff_base
				+ idct_pkg::sram_addr_t'(rd_cnt[5:3]) * idct_pkg::sram_addr_t'(`IMG_WIDTH)
				+ idct_pkg::sram_addr_t'(rd_cnt[2:0]);
			ret_idx[0] <= rd_cnt;
		end
		for (int i = 1; i <= LAT; i++) begin
			ret_idx[i] <= ret_idx[i-1];
		end
		if (state == idct_pkg::IO_WRITE && pixel_valid) begin
			if (!pix_odd) begin
				pix_hi <= pixel;                       // Even column, high byte
			end else begin
				sram_write_data <= {pix_hi, pixel};
				sram_address <= pix_base
					+ idct_pkg::sram_addr_t'(word_cnt[4:2]) * idct_pkg::sram_addr_t'(`ROW_WORDS)
					+ idct_pkg::sram_addr_t'(word_cnt[1:0]);
			end
		end
	end

	a_no_write_in_read: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		state == idct_pkg::IO_READ |-> sram_we_n);

endmodule

//--- src/idct_mac.sv
// Two-product multiply-accumulate for the IDCT passes, gives the scaled T value and the clipped pixel
`timescale 1ns/1ns
`include "idct_defs.svh"

module idct_mac (
	input  logic              CLOCK_50_I,
	input  logic              resetn,
	input  idct_pkg::sample_t a0,
	input  idct_pkg::sample_t a1,
	input  idct_pkg::coeff_t  c0,
	input  idct_pkg::coeff_t  c1,
	input  logic              mac_valid,
	input  logic              mac_first,
	input  logic              mac_last,
	output idct_pkg::sample_t t_value,
	output idct_pkg::pixel_t  pixel,
	output logic              result_valid
);

	localparam int ACC_MSB = $bits(idct_pkg::acc_t) - 1;

	idct_pkg::sample_t a0_q, a1_q;
	idct_pkg::coeff_t  c0_q, c1_q;
	logic              valid_q, first_q, last_q;
	logic signed [31:0] prod0, prod1;
	idct_pkg::acc_t    acc, acc_base, sum;

	assign prod0    = a0_q * c0_q;
	assign prod1    = a1_q * c1_q;
	assign acc_base = first_q ? '0 : acc;     // New dot product restarts
	assign sum      = acc_base + idct_pkg::acc_t'(prod0) + idct_pkg::acc_t'(prod1);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			valid_q      <= 1'b0;
			first_q      <= 1'b0;
			last_q       <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			valid_q      <= mac_valid;
			first_q      <= mac_first;
			last_q       <= mac_last;
			result_valid <= valid_q && last_q;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		a0_q <= a0;
		a1_q <= a1;
		c0_q <= c0;
		c1_q <= c1;
		if (valid_q) begin
			acc <= sum;
		end
		if (valid_q && last_q) begin
			t_value <= sum[`PASS1_SHIFT +: 16];
			if (sum[ACC_MSB]) begin
				pixel <= 8'd0;
			end else if (|sum[ACC_MSB-1:`CLIP_BIT]) begin
				pixel <= 8'd255;                   // Saturate high
			end else begin
				pixel <= sum[`PIXEL_LSB +: 8];
			end
		end
	end

endmodule

//--- src/idct_ctrl.sv
// Top FSM of the IDCT engine, sequences fetch, both matrix passes and write-back
`timescale 1ns/1ns
`include "idct_defs.svh"

module idct_ctrl (
	input  logic               CLOCK_50_I,
	input  logic               resetn,
	input  logic               start,
	output logic               busy,
	output logic               done,
	output logic               fetch_start,
	input  logic               fetch_done,
	input  logic               write_done,
	output idct_pkg::mat_idx_t sp_rd_addr_a,
	output idct_pkg::mat_idx_t sp_rd_addr_b,
	output idct_pkg::mat_idx_t t_rd_addr_a,
	output idct_pkg::mat_idx_t t_rd_addr_b,
	output idct_pkg::mat_idx_t t_wr_addr,
	output logic               t_wr_en,
	output idct_pkg::mat_idx_t rom_addr_a,
	output idct_pkg::mat_idx_t rom_addr_b,
	output logic               mac_valid,
	output logic               mac_first,
	output logic               mac_last,
	input  logic               result_valid,
	output logic               operand_sel
);

	localparam logic [2:0] LAST_IDX = 3'(`IDCT_N - 1);

	idct_pkg::ctrl_state_t state;
	logic       issuing;
	logic [2:0] row_cnt, col_cnt;
	logic [1:0] pair_cnt;              // Terms 2p and 2p+1
	logic       pair_last, issue_last;
	logic [2:0] rom_col;

	assign pair_last  = (pair_cnt == 2'd3);
	assign issue_last = issuing && pair_last && col_cnt == LAST_IDX && row_cnt == LAST_IDX;

	assign busy    = (state != idct_pkg::CTRL_IDLE) && (state != idct_pkg::CTRL_DONE);
	assign done    = (state == idct_pkg::CTRL_DONE);
	assign t_wr_en = result_valid && !operand_sel;   // Pass 1 results only

	// Pass 1 walks S' rows against C columns, pass 2 C columns against T columns
	assign sp_rd_addr_a = {row_cnt, pair_cnt, 1'b0};
	assign sp_rd_addr_b = {row_cnt, pair_cnt, 1'b1};
	assign t_rd_addr_a  = {pair_cnt, 1'b0, col_cnt};
	assign t_rd_addr_b  = {pair_cnt, 1'b1, col_cnt};
	assign rom_col      = (state == idct_pkg::CTRL_PASS2) ? row_cnt : col_cnt;
	assign rom_addr_a   = {pair_cnt, 1'b0, rom_col};
	assign rom_addr_b   = {pair_cnt, 1'b1, rom_col};

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state       <= idct_pkg::CTRL_IDLE;
			issuing     <= 1'b0;
			row_cnt     <= '0;
			col_cnt     <= '0;
			pair_cnt    <= '0;
			fetch_start <= 1'b0;
			mac_valid   <= 1'b0;
			mac_first   <= 1'b0;
			mac_last    <= 1'b0;
			operand_sel <= 1'b0;
			t_wr_addr   <= '0;
		end else begin
			fetch_start <= 1'b0;
			mac_valid   <= issuing;                  // Lines up with RAM/ROM data
			mac_first   <= issuing && pair_cnt == 2'd0;
			mac_last    <= issuing && pair_last;
			operand_sel <= (state == idct_pkg::CTRL_PASS2) || (state == idct_pkg::CTRL_DRAIN);
			if (t_wr_en) begin
				t_wr_addr <= t_wr_addr + 6'd1;
			end
			if (issuing) begin
				pair_cnt <= pair_cnt + 2'd1;
				if (pair_last) begin
					col_cnt <= col_cnt + 3'd1;
					if (col_cnt == LAST_IDX) begin
						row_cnt <= row_cnt + 3'd1;
					end
				end
				if (issue_last) begin
					issuing <= 1'b0;
				end
			end
			case (state)
				idct_pkg::CTRL_IDLE, idct_pkg::CTRL_DONE: begin
					if (start) begin
						fetch_start <= 1'b1;
						state       <= idct_pkg::CTRL_FETCH;
					end else begin
						state <= idct_pkg::CTRL_IDLE;
					end
				end
				idct_pkg::CTRL_FETCH: begin
					if (fetch_done) begin
						state     <= idct_pkg::CTRL_PASS1;
						issuing   <= 1'b1;
						row_cnt   <= '0;
						col_cnt   <= '0;
						pair_cnt  <= '0;
						t_wr_addr <= '0;
					end
				end
				idct_pkg::CTRL_PASS1: begin
					if (t_wr_en && t_wr_addr == 6'd63) begin   // T complete
						state   <= idct_pkg::CTRL_PASS2;
						issuing <= 1'b1;
					end
				end
				idct_pkg::CTRL_PASS2: begin
					if (issue_last) begin
						state <= idct_pkg::CTRL_DRAIN;
					end
				end
				idct_pkg::CTRL_DRAIN: begin
					if (write_done) begin
						state <= idct_pkg::CTRL_DONE;
					end
				end
				default: state <= idct_pkg::CTRL_IDLE;
			endcase
		end
	end

	a_t_write_pass1: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		t_wr_en |-> state == idct_pkg::CTRL_PASS1);

endmodule

//--- src/idct_top.sv
// Top level of the 8x8 inverse DCT engine, connects control, SRAM I/O, MAC, ROM and RAMs
`timescale 1ns/1ns

module idct_top (
	input  logic                 CLOCK_50_I,
	input  logic                 resetn,
	input  logic                 start,
	input  idct_pkg::blk_row_t   block_row,
	input  idct_pkg::blk_col_t   block_col,
	output logic                 busy,
	output logic                 done,
	input  idct_pkg::sram_data_t sram_read_data,
	output idct_pkg::sram_data_t sram_write_data,
	output idct_pkg::sram_addr_t sram_address,
	output logic                 sram_we_n
);

	logic               fetch_start, fetch_done, write_done;
	idct_pkg::mat_idx_t sp_wr_addr, sp_rd_addr_a, sp_rd_addr_b, sp_addr_a;
	idct_pkg::sample_t  sp_wr_data, sp_q_a, sp_q_b;
	logic               sp_wr_en;
	idct_pkg::mat_idx_t t_rd_addr_a, t_rd_addr_b, t_wr_addr, t_addr_a;
	idct_pkg::sample_t  t_q_a, t_q_b, t_value;
	logic               t_wr_en;
	idct_pkg::mat_idx_t rom_addr_a, rom_addr_b;
	idct_pkg::coeff_t   coeff_a, coeff_b;
	logic               mac_valid, mac_first, mac_last, result_valid, operand_sel;
	idct_pkg::sample_t  mac_a0, mac_a1;
	idct_pkg::pixel_t   pixel;
	logic               pixel_valid;

	assign sp_addr_a   = sp_wr_en ? sp_wr_addr : sp_rd_addr_a;   // Fetch owns port a
	assign t_addr_a    = t_wr_en ? t_wr_addr : t_rd_addr_a;
	assign mac_a0      = operand_sel ? t_q_a : sp_q_a;            // T in pass 2
	assign mac_a1      = operand_sel ? t_q_b : sp_q_b;
	assign pixel_valid = result_valid && operand_sel;

	idct_ctrl u_ctrl (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .start(start), .busy(busy), .done(done),
		.fetch_start(fetch_start), .fetch_done(fetch_done), .write_done(write_done),
		.sp_rd_addr_a(sp_rd_addr_a), .sp_rd_addr_b(sp_rd_addr_b),
		.t_rd_addr_a(t_rd_addr_a), .t_rd_addr_b(t_rd_addr_b),
		.t_wr_addr(t_wr_addr), .t_wr_en(t_wr_en),
		.rom_addr_a(rom_addr_a), .rom_addr_b(rom_addr_b),
		.mac_valid(mac_valid), .mac_first(mac_first), .mac_last(mac_last),
		.result_valid(result_valid), .operand_sel(operand_sel)
	);

	sram_block_io u_sram_io (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .fetch_start(fetch_start),
		.block_row(block_row), .block_col(block_col), .sram_read_data(sram_read_data),
		.sram_address(sram_address), .sram_write_data(sram_write_data), .sram_we_n(sram_we_n),
		.sp_wr_addr(sp_wr_addr), .sp_wr_data(sp_wr_data), .sp_wr_en(sp_wr_en),
		.fetch_done(fetch_done), .pixel(pixel), .pixel_valid(pixel_valid),
		.write_done(write_done)
	);

	idct_mac u_mac (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn),
		.a0(mac_a0), .a1(mac_a1), .c0(coeff_a), .c1(coeff_b),
		.mac_valid(mac_valid), .mac_first(mac_first), .mac_last(mac_last),
		.t_value(t_value), .pixel(pixel), .result_valid(result_valid)
	);

	dct_coeff_rom u_rom (
		.CLOCK_50_I(CLOCK_50_I), .addr_a(rom_addr_a), .addr_b(rom_addr_b),
		.coeff_a(coeff_a), .coeff_b(coeff_b)
	);

	dp_ram #(
		.WIDTH($bits(idct_pkg::sample_t)), .DEPTH_LOG2($bits(idct_pkg::mat_idx_t))
	) u_sp_ram (
		.CLOCK_50_I(CLOCK_50_I), .addr_a(sp_addr_a), .addr_b(sp_rd_addr_b),
		.data_a(sp_wr_data), .wren_a(sp_wr_en), .q_a(sp_q_a), .q_b(sp_q_b)
	);

	dp_ram #(
		.WIDTH($bits(idct_pkg::sample_t)), .DEPTH_LOG2($bits(idct_pkg::mat_idx_t))
	) u_t_ram (
		.CLOCK_50_I(CLOCK_50_I), .addr_a(t_addr_a), .addr_b(t_rd_addr_b),
		.data_a(t_value), .wren_a(t_wr_en), .q_a(t_q_a), .q_b(t_q_b)
	);

endmodule

//--- dv/sram_model.sv
// Behavioral 256K x 16 SRAM for the IDCT testbench, two-cycle reads and writes while we_n is low
`timescale 1ns/1ns

module sram_model (
	input  logic                 CLOCK_50_I,
	input  idct_pkg::sram_addr_t address,
	input  idct_pkg::sram_data_t write_data,
	input  logic                 we_n,
	output idct_pkg::sram_data_t read_data
);

	idct_pkg::sram_data_t mem [2**18];
	idct_pkg::sram_addr_t addr_q;

	initial begin
		addr_q    = '0;
		read_data = '0;
		for (int i = 0; i < 2**18; i++) begin
			mem[i] = 16'(i) ^ 16'(i >> 16) ^ 16'h5a3c;   // Depends on all 18 bits
		end
	end

	always @(posedge CLOCK_50_I) begin
		addr_q    <= address;
		read_data <= mem[addr_q];                        // Data one cycle after the sample
		if (!we_n) begin
			mem[address] <= write_data;
		end
	end

endmodule

//--- dv/tb_idct_top.sv
// Testbench for the IDCT engine, runs coefficient blocks through the SRAM model and checks pixels
`timescale 1ns/1ns
`include "idct_defs.svh"

module tb_idct_top;

	logic                 CLOCK_50_I;
	logic                 resetn;
	logic                 start;
	idct_pkg::blk_row_t   block_row;
	idct_pkg::blk_col_t   block_col;
	logic                 busy, done, sram_we_n;
	idct_pkg::sram_data_t sram_read_data, sram_write_data;
	idct_pkg::sram_addr_t sram_address;

	logic signed [15:0] coef_blk [64];
	logic [15:0]        exp_words [32];
	int                 errors = 0;
	int                 errors_at_start = 0;
	int                 tests_run = 0;
	int                 tests_failed = 0;
	int                 done_count = 0;
	int                 done_seen;
	bit                 has_lo, has_hi;

	idct_top u_dut (
		.CLOCK_50_I(CLOCK_50_I), .resetn(resetn), .start(start), .block_row(block_row),
		.block_col(block_col), .busy(busy), .done(done), .sram_read_data(sram_read_data),
		.sram_write_data(sram_write_data), .sram_address(sram_address), .sram_we_n(sram_we_n)
	);

	sram_model u_sram (
		.CLOCK_50_I(CLOCK_50_I), .address(sram_address), .write_data(sram_write_data),
		.we_n(sram_we_n), .read_data(sram_read_data)
	);

	always #5 CLOCK_50_I = ~CLOCK_50_I;

	always @(negedge CLOCK_50_I) begin
		if (resetn && done) begin
			done_count++;   // Sampled away from the edge
		end
	end

	// C[n][k], sign from the cosine itself, magnitude from the folded phase
	function automatic int cos_ref(input int n, input int k);
		int m;
		int mag;
		begin
			if (k == 0) begin
				return 1448;
			end
			m = ((2 * n + 1) * k) % 32;
			if (m > 16) begin
				m = 32 - m;
			end
			if (m > 8) begin
				m = 16 - m;
			end
			case (m)
				1:       mag = 2008;
				2:       mag = 1892;
				3:       mag = 1702;
				4:       mag = 1448;
				5:       mag = 1137;
				6:       mag = 783;
				default: mag = 399;
			endcase
			return ($cos(real'((2 * n + 1) * k) * 3.14159265358979 / 16.0) < 0.0) ? -mag : mag;
		end
	endfunction

	function automatic void idct_ref(input logic signed [15:0] s [64], output logic [15:0] w [32]);
		longint             sum;
		logic signed [15:0] t [64];
		logic [7:0]         pix;
		begin
			for (int r = 0; r < 8; r++) begin
				for (int c = 0; c < 8; c++) begin
					sum = 0;
					for (int k = 0; k < 8; k++) begin
						sum += longint'(s[r * 8 + k]) * cos_ref(k, c);
					end
					t[r * 8 + c] = sum[23:8];
				end
			end
			for (int i = 0; i < 8; i++) begin
				for (int j = 0; j < 8; j++) begin
					sum = 0;
					for (int k = 0; k < 8; k++) begin
						sum += longint'(t[k * 8 + j]) * cos_ref(k, i);
					end
					if (sum < 0) begin
						pix = 8'd0;
					end else if (sum >= 64'sd16777216) begin
						pix = 8'd255;
					end else begin
						pix = sum[23:16];
					end
					if (j % 2 == 0) begin
						w[i * 4 + j / 2][15:8] = pix;   // Even column high
					end else begin
						w[i * 4 + j / 2][7:0] = pix;
					end
				end
			end
		end
	endfunction

	function automatic idct_pkg::sram_addr_t coef_addr(input int br, input int bc, input int r,
			input int c);
		return idct_pkg::sram_addr_t'(`COEFF_BASE + br * 2560 + bc * 8 + r * 320 + c);
	endfunction

	function automatic idct_pkg::sram_addr_t pix_addr(input int br, input int bc, input int r,
			input int w);
		return idct_pkg::sram_addr_t'(br * 1280 + bc * 4 + r * 160 + w);
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic fill_random(input int span);
		for (int i = 0; i < 64; i++) begin
			coef_blk[i] = 16'(int'($urandom % (2 * span + 1)) - span);
		end
	endtask

	// Also predicts the words the run must write
	task automatic load_block(input int br, input int bc);
		for (int i = 0; i < 64; i++) begin
			u_sram.mem[coef_addr(br, bc, i / 8, i % 8)] = coef_blk[i];
		end
		for (int w = 0; w < 32; w++) begin
			u_sram.mem[pix_addr(br, bc, w / 4, w % 4)] = 16'h5a5a;   // Stale pixels
		end
		idct_ref(coef_blk, exp_words);
	endtask

	task automatic run_block(input int br, input int bc, input bit restart_busy);
		int cycles;
		int done_before;
		begin
			done_before = done_count;
			block_row   = 5'(br);
			block_col   = 6'(bc);
			start       = 1'b1;
			@(posedge CLOCK_50_I);
			#1;
			start  = 1'b0;
			cycles = 0;
			while (!done && cycles < 20000) begin
				@(posedge CLOCK_50_I);
				#1;
				cycles++;
				start = restart_busy && cycles == 20;   // Must be ignored
				if (cycles == 20) begin
					check_value("busy", 16'd1, 16'(busy));
				end
			end
			start = 1'b0;
			if (!done) begin
				$display("ERROR at %0t ns: done did not rise within 20000 cycles", $time);
				errors++;
			end else begin
				check_value("busy", 16'd0, 16'(busy));
				@(posedge CLOCK_50_I);
				#1;
				check_value("done", 16'd0, 16'(done));
				if (done_count != done_before + 1) begin
					$display("ERROR at %0t ns: done pulsed %0d times in one run", $time,
						done_count - done_before);
					errors++;
				end
			end
		end
	endtask

	task automatic compare_block(input int br, input int bc);
		idct_pkg::sram_addr_t addr;
		begin
			for (int w = 0; w < 32; w++) begin
				addr = pix_addr(br, bc, w / 4, w % 4);
				check_value($sformatf("sram mem[%0d]", addr), exp_words[w], u_sram.mem[addr]);
			end
		end
	endtask

	task automatic set_sentinels(input int br, input int bc);
		for (int r = 0; r < 8; r++) begin
			u_sram.mem[pix_addr(br, bc, r, -1)] = 16'hbe00 + 16'(r);
			u_sram.mem[pix_addr(br, bc, r, 4)]  = 16'hef00 + 16'(r);
		end
	endtask

	task automatic check_sentinels(input int br, input int bc);
		idct_pkg::sram_addr_t left, right;
		begin
			for (int r = 0; r < 8; r++) begin
				left  = pix_addr(br, bc, r, -1);
				right = pix_addr(br, bc, r, 4);
				check_value($sformatf("sram mem[%0d]", left), 16'hbe00 + 16'(r), u_sram.mem[left]);
				check_value($sformatf("sram mem[%0d]", right), 16'hef00 + 16'(r), u_sram.mem[right]);
			end
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
			$display("test %0d, %s: FAIL with %0d errors", tests_run, name, errors - errors_at_start);
		end else begin
			$display("test %0d, %s: ok", tests_run, name);
		end
		errors_at_start = errors;
	endtask

	initial begin
		CLOCK_50_I = 1'b0;
		resetn     = 1'b0;
		start      = 1'b0;
		block_row  = '0;
		block_col  = '0;
		void'($urandom(55));
		repeat (8) @(posedge CLOCK_50_I);
		#1;
		resetn = 1'b1;

		check_value("busy", 16'd0, 16'(busy));
		check_value("done", 16'd0, 16'(done));
		check_value("sram_we_n", 16'd1, 16'(sram_we_n));
		end_test("outputs after reset");

		coef_blk = '{default: '0};
		load_block(0, 0);
		run_block(0, 0, 1'b0);
		compare_block(0, 0);
		end_test("zero block at (0,0)");

		coef_blk    = '{default: '0};
		coef_blk[0] = 16'sd800;   // Mid-gray flat block
		load_block(3, 5);
		run_block(3, 5, 1'b0);
		compare_block(3, 5);
		end_test("DC block at (3,5)");

		fill_random(64);
		load_block(3, 5);
		run_block(3, 5, 1'b0);
		compare_block(3, 5);
		end_test("random block within +-64 at (3,5)");

		fill_random(512);
		load_block(10, 20);
		has_lo = 1'b0;
		has_hi = 1'b0;
		for (int w = 0; w < 32; w++) begin
			has_lo |= exp_words[w][15:8] == 8'h00 || exp_words[w][7:0] == 8'h00;
			has_hi |= exp_words[w][15:8] == 8'hff || exp_words[w][7:0] == 8'hff;
		end
		if (!(has_lo && has_hi)) begin
			$display("ERROR at %0t ns: large random block reaches only one clip limit", $time);
			errors++;
		end
		set_sentinels(10, 20);
		run_block(10, 20, 1'b0);
		compare_block(10, 20);
		check_sentinels(10, 20);
		end_test("clipping block with sentinels at (10,20)");

		fill_random(256);
		load_block(1, 2);
		run_block(1, 2, 1'b1);
		compare_block(1, 2);
		done_seen = done_count;
		repeat (30) @(posedge CLOCK_50_I);
		#1;
		check_value("busy", 16'd0, 16'(busy));   // Restart left no second run behind
		if (done_count != done_seen) begin
			$display("ERROR at %0t ns: done pulsed again without a start", $time);
			errors++;
		end
		fill_random(128);
		load_block(2, 6);
		run_block(2, 6, 1'b0);
		compare_block(2, 6);
		end_test("start while busy, then a second run");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- idct_block.f
+incdir+include
src/idct_pkg.sv
src/dp_ram.sv
src/dct_coeff_rom.sv
src/sram_block_io.sv
src/idct_mac.sv
src/idct_ctrl.sv
src/idct_top.sv
dv/sram_model.sv
dv/tb_idct_top.sv

//--- Makefile
TOP = tb_idct_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f idct_block.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
